// ==== cpu_bus_top.f ====
+incdir+include
logic/cpu_bus_pkg.sv
logic/bus_arbiter.sv
logic/axi_read_port.sv
logic/axi_write_port.sv
logic/clint_timer.sv
logic/cpu_bus_top.sv
dv/axi_mem_model.sv
dv/cpu_bus_tb.sv

// ==== dv/axi_mem_model.sv ====
`timescale 1ns/1ps

module axi_mem_model (
  input  logic        clk,
  input  logic        rst,
  input  logic [31:0] araddr_i,
  input  logic        arvalid_i,
  output logic        arready_o,
  output logic [63:0] rdata_o,
  output logic        rvalid_o,
  output logic [1:0]  rresp_o,
  output logic [3:0]  rid_o,
  output logic        rlast_o,
  input  logic [31:0] awaddr_i,
  input  logic        awvalid_i,
  output logic        awready_o,
  input  logic [63:0] wdata_i,
  input  logic [7:0]  wstrb_i,
  input  logic        wvalid_i,
  output logic        wready_o,
  output logic        bvalid_o,
  output logic [1:0]  bresp_o,
  output logic [3:0]  bid_o
);
  logic [7:0]  mem [bit [31:0]];  // stored bytes only
  logic [1:0]  ar_dly;
  logic [1:0]  aw_dly;
  logic [1:0]  w_dly;
  logic        aw_got;
  logic        w_got;
  logic [31:0] aw_addr;
  logic [63:0] w_data;
  logic [7:0]  w_strb;

  assign rresp_o = 2'b00;
  assign rid_o   = 4'h0;
  assign rlast_o = 1'b1;
  assign bresp_o = 2'b00;
  assign bid_o   = 4'h0;

  // untouched bytes follow the preload word
  function automatic logic [7:0] peek(input logic [31:0] a);
    logic [31:0] w;
    w = {a[31:2], 2'b00} ^ 32'h5a5a_0000;
    if (mem.exists(a)) return mem[a];
    return w[8*a[1:0] +: 8];
  endfunction

  function automatic logic [63:0] beat(input logic [31:0] a);
    logic [63:0] d;
    for (int i = 0; i < 8; i++) begin
      d[8*i +: 8] = peek({a[31:3], 3'b000} + i);
    end
    return d;
  endfunction

  always @(posedge clk) begin
    if (rst) begin
      arready_o <= 1'b0;
      awready_o <= 1'b0;
      wready_o  <= 1'b0;
      rvalid_o  <= 1'b0;
      bvalid_o  <= 1'b0;
      ar_dly    <= 2'($urandom_range(3, 0));
      aw_dly    <= 2'($urandom_range(3, 0));
      w_dly     <= 2'($urandom_range(3, 0));
      aw_got    <= 1'b0;
      w_got     <= 1'b0;
    end else begin
      rvalid_o <= 1'b0;
      bvalid_o <= 1'b0;
      if (arvalid_i && arready_o) begin
        arready_o <= 1'b0;
        ar_dly    <= 2'($urandom_range(3, 0));
        rvalid_o  <= 1'b1;  // single beat, next cycle
        rdata_o   <= beat(araddr_i);
      end else if (arvalid_i) begin
        if (ar_dly == 2'd0) arready_o <= 1'b1;
        else ar_dly <= ar_dly - 2'd1;
      end
      if (awvalid_i && awready_o) begin
        awready_o <= 1'b0;
        aw_dly    <= 2'($urandom_range(3, 0));
        aw_got    <= 1'b1;
        aw_addr   <= awaddr_i;
      end else if (awvalid_i && !aw_got) begin
        if (aw_dly == 2'd0) awready_o <= 1'b1;
        else aw_dly <= aw_dly - 2'd1;
      end
      if (wvalid_i && wready_o) begin
        wready_o <= 1'b0;
        w_dly    <= 2'($urandom_range(3, 0));
        w_got    <= 1'b1;
        w_data   <= wdata_i;
        w_strb   <= wstrb_i;
      end else if (wvalid_i && !w_got) begin
        if (w_dly == 2'd0) wready_o <= 1'b1;
        else w_dly <= w_dly - 2'd1;
      end
      // aw and w may arrive in either order
      if (aw_got && w_got) begin
        for (int i = 0; i < 8; i++) begin
          if (w_strb[i]) mem[{aw_addr[31:3], 3'b000} + i] = w_data[8*i +: 8];
        end
        aw_got   <= 1'b0;
        w_got    <= 1'b0;
        bvalid_o <= 1'b1;
      end
    end
  end

endmodule

// ==== dv/cpu_bus_tb.sv ====
`timescale 1ns/1ps
`include "cpu_bus_consts.svh"

module cpu_bus_tb;
  import cpu_bus_pkg::*;

  localparam int TIMEOUT = 200;
  localparam int K_IFU   = 0;
  localparam int K_LSU   = 1;
  localparam int K_STORE = 2;
  localparam int K_CLINT = 3;
  localparam int K_DUAL  = 4;  // ifu at addr, lsu at addr + 4

  logic     clk;
  logic     rst;
  rd_req_t  ifu_req;
  logic     ifu_valid;
  rd_resp_t ifu_resp;
  rd_req_t  lsu_rd;
  logic     lsu_rd_valid;
  rd_resp_t lsu_resp;
  wr_req_t  lsu_wr;
  logic     wr_done;

  logic [31:0] araddr;
  logic [2:0]  arsize;
  logic [7:0]  arlen;
  logic [1:0]  arburst;
  logic [3:0]  arid;
  logic        arvalid;
  logic        arready;
  logic [63:0] rdata;
  logic        rvalid;
  logic [1:0]  rresp;
  logic [3:0]  rid;
  logic        rlast;
  logic        rready;
  logic [31:0] awaddr;
  logic [2:0]  awsize;
  logic [7:0]  awlen;
  logic [1:0]  awburst;
  logic [3:0]  awid;
  logic        awvalid;
  logic        awready;
  logic [63:0] wdata;
  logic [7:0]  wstrb;
  logic        wlast;
  logic        wvalid;
  logic        wready;
  logic        bvalid;
  logic [1:0]  bresp;
  logic [3:0]  bid;
  logic        bready;

  string       t_name [$];
  int          t_kind [$];
  logic [31:0] t_addr [$];
  logic [31:0] t_data [$];
  logic [3:0]  t_strb [$];
  logic [31:0] t_exp [$];
  logic [31:0] t_exp2 [$];
  logic [31:0] shadow [bit [31:0]];  // expected words after stores

  int          ntests;
  int          nfail;
  int          nstores;
  int          ndone;
  logic [31:0] last_rtc;
  logic        attr_ok;
  int          seed_init;

  cpu_bus_top UUT (
    .clk (clk), .rst (rst),
    .ifu_req_i (ifu_req), .ifu_valid_i (ifu_valid), .ifu_resp_o (ifu_resp),
    .lsu_rd_i (lsu_rd), .lsu_rd_valid_i (lsu_rd_valid), .lsu_resp_o (lsu_resp),
    .lsu_wr_i (lsu_wr), .lsu_wr_done_o (wr_done),
    .io_master_araddr_o (araddr), .io_master_arsize_o (arsize), .io_master_arlen_o (arlen),
    .io_master_arburst_o (arburst), .io_master_arid_o (arid),
    .io_master_arvalid_o (arvalid),
    .io_master_arready_i (arready), .io_master_rdata_i (rdata),
    .io_master_rvalid_i (rvalid), .io_master_rresp_i (rresp), .io_master_rid_i (rid),
    .io_master_rlast_i (rlast), .io_master_rready_o (rready),
    .io_master_awaddr_o (awaddr), .io_master_awsize_o (awsize), .io_master_awlen_o (awlen),
    .io_master_awburst_o (awburst), .io_master_awid_o (awid),
    .io_master_awvalid_o (awvalid),
    .io_master_awready_i (awready), .io_master_wdata_o (wdata),
    .io_master_wstrb_o (wstrb), .io_master_wlast_o (wlast),
    .io_master_wvalid_o (wvalid), .io_master_wready_i (wready),
    .io_master_bvalid_i (bvalid), .io_master_bresp_i (bresp), .io_master_bid_i (bid),
    .io_master_bready_o (bready)
  );

  axi_mem_model slave (
    .clk (clk), .rst (rst),
    .araddr_i (araddr), .arvalid_i (arvalid), .arready_o (arready),
    .rdata_o (rdata), .rvalid_o (rvalid), .rresp_o (rresp), .rid_o (rid),
    .rlast_o (rlast), .awaddr_i (awaddr), .awvalid_i (awvalid), .awready_o (awready),
    .wdata_i (wdata), .wstrb_i (wstrb), .wvalid_i (wvalid), .wready_o (wready),
    .bvalid_o (bvalid), .bresp_o (bresp), .bid_o (bid)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(negedge clk) begin
    if (!rst && wr_done) ndone++;
  end

  function automatic logic [31:0] mem_word(input logic [31:0] a);
    logic [31:0] wa;
    wa = {a[31:2], 2'b00};
    if (shadow.exists(wa)) return shadow[wa];
    return wa ^ 32'h5a5a_0000;  // preload rule
  endfunction

  function automatic logic [31:0] merge_store(input logic [31:0] old, input logic [31:0] d,
                                             input logic [3:0] s, input logic [1:0] off);
    logic [31:0] dsh;
    logic [3:0]  ssh;
    logic [31:0] r;
    dsh = d << (8 * off);
    ssh = s << off;
    r = old;
    for (int b = 0; b < 4; b++) begin
      if (ssh[b]) r[8*b +: 8] = dsh[8*b +: 8];
    end
    return r;
  endfunction

  // axi size code, log2 of the strobed byte count
  function automatic logic [2:0] strb_size(input logic [3:0] s);
    case ($countones(s))
      4: return 3'd2;
      2: return 3'd1;
      default: return 3'd0;
    endcase
  endfunction

  // expected values are fixed here, in table order
  task automatic add_row(input string nm, input int k, input logic [31:0] a,
                         input logic [31:0] d, input logic [3:0] s);
    logic [31:0] e;
    logic [31:0] e2;
    e  = mem_word(a);
    e2 = mem_word(a + 32'd4);
    if (k == K_STORE) begin
      e = merge_store(mem_word(a), d, s, a[1:0]);
      shadow[{a[31:2], 2'b00}] = e;
      nstores++;
    end
    if (k == K_CLINT) e = 32'd0;  // upper mtime word
    t_name.push_back(nm);
    t_kind.push_back(k);
    t_addr.push_back(a);
    t_data.push_back(d);
    t_strb.push_back(s);
    t_exp.push_back(e);
    t_exp2.push_back(e2);
  endtask

  task automatic build_table();
    add_row("ifu_lo", K_IFU, 32'h8000_0000, 32'h0, 4'h0);
    add_row("ifu_hi", K_IFU, 32'h8000_0004, 32'h0, 4'h0);
    add_row("lsu_lo", K_LSU, 32'h8000_0108, 32'h0, 4'h0);
    add_row("lsu_hi", K_LSU, 32'h8000_010c, 32'h0, 4'h0);
    add_row("st_b0", K_STORE, 32'h8000_0300, 32'h0000_0011, 4'b0001);
    add_row("st_b3", K_STORE, 32'h8000_0303, 32'h0000_0044, 4'b0001);
    add_row("ld_300", K_LSU, 32'h8000_0300, 32'h0, 4'h0);
    add_row("st_b1", K_STORE, 32'h8000_0205, 32'h0000_00c3, 4'b0001);
    add_row("st_h2", K_STORE, 32'h8000_0206, 32'h0000_beef, 4'b0011);
    add_row("ld_204", K_LSU, 32'h8000_0204, 32'h0, 4'h0);
    add_row("st_w", K_STORE, 32'h8000_030c, 32'h1234_5678, 4'b1111);
    add_row("ifu_30c", K_IFU, 32'h8000_030c, 32'h0, 4'h0);
    add_row("dual_400", K_DUAL, 32'h8000_0400, 32'h0, 4'h0);
    add_row("dual_300", K_DUAL, 32'h8000_0300, 32'h0, 4'h0);
    add_row("rtc_lo0", K_CLINT, `CPU_BUS_RTC_ADDR, 32'h0, 4'h0);
    add_row("rtc_up", K_CLINT, `CPU_BUS_RTC_ADDR_UP, 32'h0, 4'h0);
    add_row("rtc_lo1", K_CLINT, `CPU_BUS_RTC_ADDR, 32'h0, 4'h0);
    for (int k = 0; k < 6; k++) begin
      add_row($sformatf("rnd%0d", k), (k % 2 == 0) ? K_IFU : K_LSU,
              32'h8000_0000 | ($urandom & 32'h0000_0ffc), 32'h0, 4'h0);
    end
  endtask

  task automatic check_eq(input string nm, input logic [31:0] exp, input logic [31:0] act,
                          inout logic ok);
    assert (act === exp) else begin
      $display("ERR %s exp=%08h act=%08h", nm, exp, act);
      ok = 1'b0;
    end
  endtask

  task automatic finish_test(input string nm, input logic ok);
    ntests++;
    if (ok) $display("ok   %s", nm);
    else begin
      nfail++;
      $display("fail %s", nm);
    end
  endtask

  // fixed axi fields, checked where each handshake happens
  always @(negedge clk) begin
    if (!rst) begin
      check_eq("rready", 32'd1, 32'(rready), attr_ok);
      check_eq("bready", 32'd1, 32'(bready), attr_ok);
      if (arvalid && arready) begin
        check_eq("ar_fields", {15'h0, 8'h0, `CPU_BUS_BURST_INCR, `CPU_BUS_AXI_ID, 3'd2},
                 {15'h0, arlen, arburst, arid, arsize}, attr_ok);
      end
      if (awvalid && awready) begin
        check_eq("aw_fields", {15'h0, 8'h0, `CPU_BUS_BURST_INCR, `CPU_BUS_AXI_ID,
                               strb_size(lsu_wr.strb)},
                 {15'h0, awlen, awburst, awid, awsize}, attr_ok);
      end
      if (wvalid && wready) check_eq("wlast", 32'd1, 32'(wlast), attr_ok);
    end
  end

  task automatic check_reset_idle();
    logic ok;
    ok = 1'b1;
    repeat (6) begin
      @(negedge clk);
      assert (!(arvalid || awvalid || wvalid || ifu_resp.valid || lsu_resp.valid ||
                wr_done)) else begin
        $display("reset_idle: a bus valid or response pulse is high with no request");
        ok = 1'b0;
      end
    end
    finish_test("reset_idle", ok);
  endtask

  task automatic run_row(input int i);
    int          k;
    int          n;
    int          t_ifu;
    int          t_lsu;
    logic        need_ifu;
    logic        need_lsu;
    logic        need_wr;
    logic        ar_hs;
    logic        ok;
    logic [31:0] v_ifu;
    logic [31:0] v_lsu;
    k        = t_kind[i];
    need_ifu = (k == K_IFU) || (k == K_DUAL);
    need_lsu = (k == K_LSU) || (k == K_DUAL) || (k == K_CLINT);
    need_wr  = (k == K_STORE);
    n     = 0;
    t_ifu = 0;
    t_lsu = 0;
    ar_hs = 1'b0;
    ok    = 1'b1;
    v_ifu = 32'h0;
    v_lsu = 32'h0;
    repeat ((k == K_CLINT) ? 10 : 2) @(posedge clk);
    if (need_ifu) begin
      ifu_req.addr <= t_addr[i];
      ifu_req.size <= 3'd2;
      ifu_valid    <= 1'b1;
    end
    if (need_lsu) begin
      lsu_rd.addr  <= (k == K_DUAL) ? t_addr[i] + 32'd4 : t_addr[i];
      lsu_rd.size  <= 3'd2;
      lsu_rd_valid <= 1'b1;
    end
    if (need_wr) begin
      lsu_wr.addr  <= t_addr[i];
      lsu_wr.data  <= t_data[i];
      lsu_wr.strb  <= t_strb[i];
      lsu_wr.valid <= 1'b1;
    end
    while ((need_ifu || need_lsu || need_wr) && n < TIMEOUT) begin
      @(negedge clk);
      n++;
      if (arvalid && arready) ar_hs = 1'b1;
      if (need_ifu && ifu_resp.valid) begin
        need_ifu = 1'b0;
        v_ifu    = ifu_resp.data;
        t_ifu    = n;
      end
      if (need_lsu && lsu_resp.valid) begin
        need_lsu = 1'b0;
        v_lsu    = lsu_resp.data;
        t_lsu    = n;
      end
      if (need_wr && wr_done) need_wr = 1'b0;
      @(posedge clk);
      if (!need_ifu) ifu_valid <= 1'b0;  // drop in the cycle after the pulse
      if (!need_lsu) lsu_rd_valid <= 1'b0;
      if (!need_wr) lsu_wr.valid <= 1'b0;
    end
    ifu_valid    <= 1'b0;
    lsu_rd_valid <= 1'b0;
    lsu_wr.valid <= 1'b0;
    if (need_ifu || need_lsu || need_wr) begin
      $display("%s: no response within %0d cycles", t_name[i], TIMEOUT);
      ok = 1'b0;
    end else if (k == K_IFU) begin
      check_eq(t_name[i], t_exp[i], v_ifu, ok);
    end else if (k == K_LSU) begin
      check_eq(t_name[i], t_exp[i], v_lsu, ok);
    end else if (k == K_DUAL) begin
      check_eq({t_name[i], "_ifu"}, t_exp[i], v_ifu, ok);
      check_eq({t_name[i], "_lsu"}, t_exp2[i], v_lsu, ok);
      assert (t_ifu < t_lsu) else begin
        $display("%s: the LSU response came before the IFU response", t_name[i]);
        ok = 1'b0;
      end
    end else if (k == K_CLINT) begin
      check_eq({t_name[i], "_lat"}, 32'd2, 32'(t_lsu - 1), ok);
      assert (!ar_hs) else begin
        $display("%s: an AR handshake happened for a CLINT read", t_name[i]);
        ok = 1'b0;
      end
      if (t_addr[i] == `CPU_BUS_RTC_ADDR_UP) begin
        check_eq(t_name[i], t_exp[i], v_lsu, ok);
      end else begin
        assert (v_lsu > last_rtc) else begin
          $display("ERR %s exp=>%08h act=%08h", t_name[i], last_rtc, v_lsu);
          ok = 1'b0;
        end
        last_rtc = v_lsu;
      end
    end
    finish_test(t_name[i], ok);
  endtask

  initial begin
    seed_init = $urandom(72);
    rst          = 1'b1;
    ifu_req      = '0;
    ifu_valid    = 1'b0;
    lsu_rd       = '0;
    lsu_rd_valid = 1'b0;
    lsu_wr       = '0;
    ntests   = 0;
    nfail    = 0;
    nstores  = 0;
    ndone    = 0;
    last_rtc = 32'h0;
    attr_ok  = 1'b1;
    build_table();
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    check_reset_idle();
    for (int i = 0; i < t_name.size(); i++) begin
      run_row(i);
    end
    repeat (4) @(posedge clk);
    begin : done_count
      logic ok;
      ok = 1'b1;
      check_eq("wr_done_count", 32'(nstores), 32'(ndone), ok);
      finish_test("wr_done_count", ok);
    end
    finish_test("axi_fields", attr_ok);
    $display("tests %0d, passed %0d, failed %0d", ntests, ntests - nfail, nfail);
    if (nfail == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== include/cpu_bus_consts.svh ====
`ifndef CPU_BUS_CONSTS_SVH
`define CPU_BUS_CONSTS_SVH

// clint mtime words, lsu loads only
`define CPU_BUS_RTC_ADDR    32'h0200_0048
`define CPU_BUS_RTC_ADDR_UP 32'h0200_004c

`define CPU_BUS_DW     32  // core side
`define CPU_BUS_AXI_DW 64  // master port

// single outstanding id, single beat
`define CPU_BUS_AXI_ID     4'h0
`define CPU_BUS_BURST_INCR 2'b01

`define CPU_BUS_RESP_OKAY 2'b00

`endif

// ==== logic/axi_read_port.sv ====
`timescale 1ns/1ps
`include "cpu_bus_consts.svh"

module axi_read_port (
  input  logic                       clk,
  input  logic                       rst,
  input  cpu_bus_pkg::rd_req_t       ar_req_i,
  input  logic                       ar_start_i,
  output logic [`CPU_BUS_DW-1:0]     araddr_o,
  output logic [2:0]                 arsize_o,
  output logic [7:0]                 arlen_o,
  output logic [1:0]                 arburst_o,
  output logic [3:0]                 arid_o,
  output logic                       arvalid_o,
  input  logic                       arready_i,
  input  logic [`CPU_BUS_AXI_DW-1:0] rdata_i,
  input  logic                       rvalid_i,
  input  logic [1:0]                 rresp_i,
  input  logic [3:0]                 rid_i,
  input  logic                       rlast_i,
  output logic                       rready_o,
  output cpu_bus_pkg::rd_resp_t      r_resp_o
);
  logic lane_hi_q;  // addr bit 2

  assign arlen_o   = 8'h0;  // single beat
  assign arburst_o = `CPU_BUS_BURST_INCR;
  assign arid_o    = `CPU_BUS_AXI_ID;
  assign rready_o  = 1'b1;

  always_ff @(posedge clk) begin
    if (rst) begin
      arvalid_o <= 1'b0;
    end else if (ar_start_i) begin
      arvalid_o <= 1'b1;
    end else if (arready_i) begin
      arvalid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (ar_start_i) begin
      araddr_o  <= ar_req_i.addr;
      arsize_o  <= ar_req_i.size;
      lane_hi_q <= ar_req_i.addr[2];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) r_resp_o.valid <= 1'b0;
    else     r_resp_o.valid <= rvalid_i && rready_o;
  end

  always_ff @(posedge clk) begin
    if (rvalid_i) begin
      r_resp_o.data <= lane_hi_q ? rdata_i[63:32] : rdata_i[31:0];
    end
  end

  a_r_okay: assert property (@(posedge clk) disable iff (rst)
    rvalid_i |-> (rresp_i == `CPU_BUS_RESP_OKAY) && rlast_i && (rid_i == `CPU_BUS_AXI_ID));

  // axi rule, address channel holds until taken
  a_ar_hold: assert property (@(posedge clk) disable iff (rst)
    (arvalid_o && !arready_i) |=> arvalid_o && $stable(araddr_o));

endmodule

// ==== logic/axi_write_port.sv ====
`timescale 1ns/1ps
`include "cpu_bus_consts.svh"

module axi_write_port (
  input  logic                         clk,
  input  logic                         rst,
  input  cpu_bus_pkg::wr_req_t         lsu_wr_i,
  output logic [`CPU_BUS_DW-1:0]       awaddr_o,
  output logic [2:0]                   awsize_o,
  output logic [7:0]                   awlen_o,
  output logic [1:0]                   awburst_o,
  output logic [3:0]                   awid_o,
  output logic                         awvalid_o,
  output logic [`CPU_BUS_AXI_DW-1:0]   wdata_o,
  output logic [`CPU_BUS_AXI_DW/8-1:0] wstrb_o,
  output logic                         wlast_o,
  output logic                         wvalid_o,
  input  logic                         awready_i,
  input  logic                         wready_i,
  input  logic                         bvalid_i,
  input  logic [1:0]                   bresp_i,
  input  logic [3:0]                   bid_i,
  output logic                         bready_o,
  output logic                         lsu_wr_done_o
);
  import cpu_bus_pkg::*;

  wr_state_e              state_q;
  logic                   aw_done_q;
  logic                   w_done_q;
  logic                   aw_hs;
  logic                   w_hs;
  logic [1:0]             offs;
  logic [`CPU_BUS_DW-1:0] wdata_sh;
  logic [3:0]             wstrb_sh;

  assign offs     = lsu_wr_i.addr[1:0];
  assign wdata_sh = lsu_wr_i.data << {offs, 3'b000};
  assign wstrb_sh = lsu_wr_i.strb << offs;

  assign awaddr_o  = lsu_wr_i.addr;
  assign awlen_o   = 8'h0;
  assign awburst_o = `CPU_BUS_BURST_INCR;
  assign awid_o    = `CPU_BUS_AXI_ID;
  assign wdata_o   = {wdata_sh, wdata_sh};  // both halves, strobe picks
  assign wstrb_o   = lsu_wr_i.addr[2] ? {wstrb_sh, 4'b0000} : {4'b0000, wstrb_sh};
  assign wlast_o   = 1'b1;
  assign bready_o  = 1'b1;

  always_comb begin
    case (lsu_wr_i.strb)
      4'b0011: awsize_o = 3'b001;
      4'b1111: awsize_o = 3'b010;
      default: awsize_o = 3'b000;  // byte
    endcase
  end

  assign awvalid_o = (state_q == WR_BUSY) && !aw_done_q;
  assign wvalid_o  = (state_q == WR_BUSY) && !w_done_q;
  assign aw_hs     = awvalid_o && awready_i;
  assign w_hs      = wvalid_o && wready_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q       <= WR_IDLE;
      aw_done_q     <= 1'b0;
      w_done_q      <= 1'b0;
      lsu_wr_done_o <= 1'b0;
    end else begin
      lsu_wr_done_o <= 1'b0;
      case (state_q)
        WR_IDLE: begin
          // valid still high during the done pulse
          if (lsu_wr_i.valid && !lsu_wr_done_o) begin
            state_q   <= WR_BUSY;
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
          end
        end
        WR_BUSY: begin
          if (aw_hs) aw_done_q <= 1'b1;
          if (w_hs)  w_done_q  <= 1'b1;
          if ((aw_done_q || aw_hs) && (w_done_q || w_hs)) state_q <= WR_RESP;
        end
        WR_RESP: begin
          if (bvalid_i && bready_o) begin
            state_q       <= WR_IDLE;
            lsu_wr_done_o <= 1'b1;
          end
        end
        default: state_q <= WR_IDLE;
      endcase
    end
  end

  a_b_okay: assert property (@(posedge clk) disable iff (rst)
    bvalid_i |-> (bresp_i == `CPU_BUS_RESP_OKAY) && (bid_i == `CPU_BUS_AXI_ID));

  a_aw_hold: assert property (@(posedge clk) disable iff (rst)
    (awvalid_o && !awready_i) |=> awvalid_o && $stable(awaddr_o));

endmodule

// ==== logic/bus_arbiter.sv ====
`timescale 1ns/1ps
`include "cpu_bus_consts.svh"

module bus_arbiter (
  input  logic                   clk,
  input  logic                   rst,
  input  cpu_bus_pkg::rd_req_t   ifu_req_i,
  input  logic                   ifu_valid_i,
  input  cpu_bus_pkg::rd_req_t   lsu_rd_i,
  input  logic                   lsu_rd_valid_i,
  input  cpu_bus_pkg::rd_resp_t  r_resp_i,
  input  cpu_bus_pkg::rd_resp_t  clint_resp_i,
  output cpu_bus_pkg::rd_req_t   ar_req_o,
  output logic                   ar_start_o,
  output logic                   clint_sel_o,
  output logic [`CPU_BUS_DW-1:0] clint_addr_o,
  output cpu_bus_pkg::rd_resp_t  ifu_resp_o,
  output cpu_bus_pkg::rd_resp_t  lsu_resp_o
);
  import cpu_bus_pkg::*;

  arb_state_e state_q;
  logic       lsu_is_clint;

  assign lsu_is_clint = (lsu_rd_i.addr == `CPU_BUS_RTC_ADDR) ||
                        (lsu_rd_i.addr == `CPU_BUS_RTC_ADDR_UP);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= ARB_IDLE;
      ar_start_o  <= 1'b0;
      clint_sel_o <= 1'b0;
    end else begin
      ar_start_o  <= 1'b0;
      clint_sel_o <= 1'b0;
      case (state_q)
        ARB_IDLE: begin
          if (ifu_valid_i) begin  // ifu has priority
            state_q    <= ARB_IF_WAIT;
            ar_start_o <= 1'b1;
          end else if (lsu_rd_valid_i && lsu_is_clint) begin
            state_q     <= ARB_CLINT_WAIT;
            clint_sel_o <= 1'b1;
          end else if (lsu_rd_valid_i) begin
            state_q    <= ARB_LS_WAIT;
            ar_start_o <= 1'b1;
          end
        end
        ARB_IF_WAIT, ARB_LS_WAIT: begin
          if (r_resp_i.valid) state_q <= ARB_IDLE;
        end
        ARB_CLINT_WAIT: begin
          if (clint_resp_i.valid) state_q <= ARB_IDLE;
        end
        default: state_q <= ARB_IDLE;
      endcase
    end
  end

  // payload, captured with the grant
  always_ff @(posedge clk) begin
    if (state_q == ARB_IDLE) begin
      ar_req_o     <= ifu_valid_i ? ifu_req_i : lsu_rd_i;
      clint_addr_o <= lsu_rd_i.addr;
    end
  end

  // steer the single response to its owner
  always_comb begin
    ifu_resp_o.data  = r_resp_i.data;
    ifu_resp_o.valid = r_resp_i.valid && (state_q == ARB_IF_WAIT);
    lsu_resp_o.data  = (state_q == ARB_CLINT_WAIT) ? clint_resp_i.data : r_resp_i.data;
    lsu_resp_o.valid = (r_resp_i.valid && (state_q == ARB_LS_WAIT)) ||
                       (clint_resp_i.valid && (state_q == ARB_CLINT_WAIT));
  end

  // every response finds its owner still waiting
  a_r_owned: assert property (@(posedge clk) disable iff (rst)
    r_resp_i.valid |-> (state_q == ARB_IF_WAIT) || (state_q == ARB_LS_WAIT));

  a_clint_owned: assert property (@(posedge clk) disable iff (rst)
    clint_resp_i.valid |-> (state_q == ARB_CLINT_WAIT));

endmodule

// ==== logic/clint_timer.sv ====
`timescale 1ns/1ps
`include "cpu_bus_consts.svh"

module clint_timer (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   clint_sel_i,
  input  logic [`CPU_BUS_DW-1:0] clint_addr_i,
  output cpu_bus_pkg::rd_resp_t  clint_resp_o
);
  logic [63:0] mtime_q;

  // free running from reset
  always_ff @(posedge clk) begin
    if (rst) begin
      mtime_q            <= 64'd0;
      clint_resp_o.valid <= 1'b0;
    end else begin
      mtime_q            <= mtime_q + 64'd1;
      clint_resp_o.valid <= clint_sel_i;
    end
  end

  always_ff @(posedge clk) begin
    if (clint_sel_i) begin
      clint_resp_o.data <= (clint_addr_i == `CPU_BUS_RTC_ADDR_UP) ? mtime_q[63:32]
                                                                 : mtime_q[31:0];
    end
  end

endmodule

// ==== logic/cpu_bus_pkg.sv ====
`include "cpu_bus_consts.svh"

package cpu_bus_pkg;

  // read request from ifu or lsu, held as a level
  typedef struct packed {
    logic [`CPU_BUS_DW-1:0] addr;
    logic [2:0]             size;  // axi size code
  } rd_req_t;

  typedef struct packed {
    logic [`CPU_BUS_DW-1:0] data;
    logic                   valid;  // one cycle
  } rd_resp_t;

  // store request, valid held until done pulse
  typedef struct packed {
    logic [`CPU_BUS_DW-1:0]   addr;
    logic [`CPU_BUS_DW-1:0]   data;
    logic [`CPU_BUS_DW/8-1:0] strb;
    logic                     valid;
  } wr_req_t;

  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_IF_WAIT,
    ARB_LS_WAIT,
    ARB_CLINT_WAIT
  } arb_state_e;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_BUSY,
    WR_RESP
  } wr_state_e;

endpackage

// ==== logic/cpu_bus_top.sv ====
`timescale 1ns/1ps
`include "cpu_bus_consts.svh"

module cpu_bus_top (
  input  logic                         clk,
  input  logic                         rst,
  // ifu
  input  cpu_bus_pkg::rd_req_t         ifu_req_i,
  input  logic                         ifu_valid_i,
  output cpu_bus_pkg::rd_resp_t        ifu_resp_o,
  // lsu
  input  cpu_bus_pkg::rd_req_t         lsu_rd_i,
  input  logic                         lsu_rd_valid_i,
  output cpu_bus_pkg::rd_resp_t        lsu_resp_o,
  input  cpu_bus_pkg::wr_req_t         lsu_wr_i,
  output logic                         lsu_wr_done_o,
  // axi4 master
  output logic [`CPU_BUS_DW-1:0]       io_master_araddr_o,
  output logic [2:0]                   io_master_arsize_o,
  output logic [7:0]                   io_master_arlen_o,
  output logic [1:0]                   io_master_arburst_o,
  output logic [3:0]                   io_master_arid_o,
  output logic                         io_master_arvalid_o,
  input  logic                         io_master_arready_i,
  input  logic [`CPU_BUS_AXI_DW-1:0]   io_master_rdata_i,
  input  logic                         io_master_rvalid_i,
  input  logic [1:0]                   io_master_rresp_i,
  input  logic [3:0]                   io_master_rid_i,
  input  logic                         io_master_rlast_i,
  output logic                         io_master_rready_o,
  output logic [`CPU_BUS_DW-1:0]       io_master_awaddr_o,
  output logic [2:0]                   io_master_awsize_o,
  output logic [7:0]                   io_master_awlen_o,
  output logic [1:0]                   io_master_awburst_o,
  output logic [3:0]                   io_master_awid_o,
  output logic                         io_master_awvalid_o,
  input  logic                         io_master_awready_i,
  output logic [`CPU_BUS_AXI_DW-1:0]   io_master_wdata_o,
  output logic [`CPU_BUS_AXI_DW/8-1:0] io_master_wstrb_o,
  output logic                         io_master_wlast_o,
  output logic                         io_master_wvalid_o,
  input  logic                         io_master_wready_i,
  input  logic                         io_master_bvalid_i,
  input  logic [1:0]                   io_master_bresp_i,
  input  logic [3:0]                   io_master_bid_i,
  output logic                         io_master_bready_o
);
  import cpu_bus_pkg::*;

  rd_req_t                ar_req;
  logic                   ar_start;
  rd_resp_t               r_resp;
  logic                   clint_sel;
  logic [`CPU_BUS_DW-1:0] clint_addr;
  rd_resp_t               clint_resp;

  bus_arbiter u_arb (
    .clk            (clk),
    .rst            (rst),
    .ifu_req_i      (ifu_req_i),
    .ifu_valid_i    (ifu_valid_i),
    .lsu_rd_i       (lsu_rd_i),
    .lsu_rd_valid_i (lsu_rd_valid_i),
    .r_resp_i       (r_resp),
    .clint_resp_i   (clint_resp),
    .ar_req_o       (ar_req),
    .ar_start_o     (ar_start),
    .clint_sel_o    (clint_sel),
    .clint_addr_o   (clint_addr),
    .ifu_resp_o     (ifu_resp_o),
    .lsu_resp_o     (lsu_resp_o)
  );

  axi_read_port u_rd (
    .clk        (clk),
    .rst        (rst),
    .ar_req_i   (ar_req),
    .ar_start_i (ar_start),
    .araddr_o   (io_master_araddr_o),
    .arsize_o   (io_master_arsize_o),
    .arlen_o    (io_master_arlen_o),
    .arburst_o  (io_master_arburst_o),
    .arid_o     (io_master_arid_o),
    .arvalid_o  (io_master_arvalid_o),
    .arready_i  (io_master_arready_i),
    .rdata_i    (io_master_rdata_i),
    .rvalid_i   (io_master_rvalid_i),
    .rresp_i    (io_master_rresp_i),
    .rid_i      (io_master_rid_i),
    .rlast_i    (io_master_rlast_i),
    .rready_o   (io_master_rready_o),
    .r_resp_o   (r_resp)
  );

  // stores bypass the arbiter
  axi_write_port u_wr (
    .clk           (clk),
    .rst           (rst),
    .lsu_wr_i      (lsu_wr_i),
    .awaddr_o      (io_master_awaddr_o),
    .awsize_o      (io_master_awsize_o),
    .awlen_o       (io_master_awlen_o),
    .awburst_o     (io_master_awburst_o),
    .awid_o        (io_master_awid_o),
    .awvalid_o     (io_master_awvalid_o),
    .wdata_o       (io_master_wdata_o),
    .wstrb_o       (io_master_wstrb_o),
    .wlast_o       (io_master_wlast_o),
    .wvalid_o      (io_master_wvalid_o),
    .awready_i     (io_master_awready_i),
    .wready_i      (io_master_wready_i),
    .bvalid_i      (io_master_bvalid_i),
    .bresp_i       (io_master_bresp_i),
    .bid_i         (io_master_bid_i),
    .bready_o      (io_master_bready_o),
    .lsu_wr_done_o (lsu_wr_done_o)
  );

  clint_timer u_clint (
    .clk          (clk),
    .rst          (rst),
    .clint_sel_i  (clint_sel),
    .clint_addr_i (clint_addr),
    .clint_resp_o (clint_resp)
  );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the cpu_bus testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f cpu_bus_top.f --top-module cpu_bus_tb -o cpu_bus_sim

out=$(./obj_dir/cpu_bus_sim)
echo "$out"

if echo "$out" | grep -qx "TEST PASS"; then
  exit 0
fi
exit 1
